// File: vlog.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/int_mul.sv
verilog/register_file.sv
verilog/control.sv
verilog/cpu_core.sv
bench/clock_gen.sv
bench/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cpu_core testbench with Verilator.
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module cpu_tb -o cpu_tb_sim

./obj_dir/cpu_tb_sim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"

// File: bench/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb
  import cpu_pkg::*;
();

  logic        clk, reset_n, waitrequest, read, write, halt;
  logic [31:0] readdata, address, writedata;

  logic [31:0] image [1024];  // program and data as loaded
  logic [31:0] mem   [1024];  // bus memory model
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];

  int pc_w, st_off, exp_total, stores_seen, wait_left;
  int value_errors, protocol_errors, other_errors;
  bit busy, stall_prev, stall_rd, stall_wr;
  logic [31:0] stall_addr, stall_wdata;

  clock_gen clk0 (.clk(clk), .reset_n(reset_n));

  cpu_core dut0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .waitrequest (waitrequest),
    .readdata    (readdata),
    .address     (address),
    .writedata   (writedata),
    .read        (read),
    .write       (write),
    .halt        (halt)
  );

  function automatic logic [31:0] encode(opcode_e op, int ra, int rb, int rc, int imm);
    return {op, ra[3:0], rb[3:0], rc[3:0], imm[15:0]};
  endfunction

  task automatic emit(opcode_e op, int ra, int rb, int rc, int imm);
    image[pc_w] = encode(op, ra, rb, rc, imm);
    pc_w++;
  endtask

  task automatic store_out(int r);  // results go to r15 + running offset
    emit(op_st, r, 15, 0, st_off);
    st_off += 4;
  endtask

  task automatic build_program();
    int loop_top;
    foreach (image[i]) image[i] = 32'hf000_0000 | (32'(i) << 12) | 32'(i);
    image[512] = $urandom;
    image[513] = $urandom;
    image[514] = $urandom & 32'h7fff_ffff;
    image[515] = $urandom | 32'h8000_0000;
    pc_w   = `CPU_RESET_PC / 4;
    st_off = 0;
    emit(op_ldi, 15, 0, 0, 32'h0a00);
    emit(op_ldi, 14, 0, 0, 32'h0810);  // operands at 0x800..0x80c
    emit(op_ldi, 1, 0, 0, 32'h7fff);
    emit(op_ldi, 2, 0, 0, -3);
    emit(op_ldi, 3, 0, 0, 32'h8000);
    emit(op_add, 4, 1, 1, 0);
    store_out(4);
    emit(op_add, 4, 2, 3, 0);
    store_out(4);
    emit(op_add, 4, 2, 2, 0);
    store_out(4);  // carry out
    emit(op_sub, 4, 1, 2, 0);
    store_out(4);
    emit(op_sub, 4, 3, 1, 0);
    store_out(4);
    emit(op_sub, 4, 2, 2, 0);
    store_out(4);
    emit(op_and, 4, 1, 2, 0);
    store_out(4);
    emit(op_or, 4, 1, 3, 0);
    store_out(4);
    emit(op_xor, 4, 2, 3, 0);
    store_out(4);
    emit(op_ld, 5, 14, 0, -16);
    emit(op_ld, 6, 14, 0, -12);
    emit(op_ld, 7, 14, 0, -8);
    emit(op_ld, 8, 14, 0, -4);
    emit(op_mul, 9, 5, 6, 0);
    store_out(9);
    emit(op_mulh, 9, 5, 6, 0);
    store_out(9);
    emit(op_mul, 9, 7, 8, 0);
    store_out(9);
    emit(op_mulh, 9, 7, 8, 0);
    store_out(9);
    emit(op_mulh, 9, 8, 2, 0);
    store_out(9);
    emit(op_st, 9, 14, 0, -32);
    emit(op_ld, 10, 14, 0, -32);
    store_out(10);
    emit(op_st, 7, 14, 0, 32'h20);
    emit(op_ld, 10, 14, 0, 32'h20);
    store_out(10);
    emit(op_bra, 0, 0, 0, 4);
    store_out(1);  // skipped
    emit(op_beq, 1, 1, 0, 4);
    store_out(2);  // skipped
    emit(op_beq, 1, 2, 0, 4);
    store_out(2);
    emit(op_bne, 1, 2, 0, 4);
    store_out(3);  // skipped
    emit(op_bne, 1, 1, 0, 4);
    store_out(3);
    emit(op_ldi, 12, 0, 0, 5);
    emit(op_ldi, 13, 0, 0, 0);
    emit(op_ldi, 11, 0, 0, 1);
    loop_top = pc_w;
    emit(op_add, 13, 13, 12, 0);
    store_out(13);
    emit(op_sub, 12, 12, 11, 0);
    emit(op_bne, 12, 0, 0, (loop_top - (pc_w + 1)) * 4);  // r0 stays zero
    emit(op_halt, 0, 0, 0, 0);
  endtask

  // ISA-level interpreter that fills the expected store list
  function automatic int run_reference();
    logic [31:0] r [16];
    logic [31:0] rm [1024];
    logic [31:0] pc, ins, imm, ea;
    logic signed [63:0] a, b, prod;
    opcode_e op;
    int ra, rb, rc, count, steps;
    foreach (r[i]) r[i] = '0;
    rm    = image;
    pc    = `CPU_RESET_PC;
    count = 0;
    for (steps = 0; steps < 10000; steps++) begin
      ins = rm[pc[11:2]];
      op  = opcode_e'(ins[31:28]);
      ra  = ins[27:24];
      rb  = ins[23:20];
      rc  = ins[19:16];
      imm = {{16{ins[15]}}, ins[15:0]};
      ea  = r[rb] + imm;
      a   = $signed(r[rb]);
      b   = $signed(r[rc]);
      prod = a * b;
      pc  = pc + 4;
      case (op)
        op_nop:  ;
        op_ldi:  r[ra] = imm;
        op_add:  r[ra] = r[rb] + r[rc];
        op_sub:  r[ra] = r[rb] - r[rc];
        op_and:  r[ra] = r[rb] & r[rc];
        op_or:   r[ra] = r[rb] | r[rc];
        op_xor:  r[ra] = r[rb] ^ r[rc];
        op_mul:  r[ra] = prod[31:0];
        op_mulh: r[ra] = prod[63:32];
        op_ld:   r[ra] = rm[ea[11:2]];
        op_st: begin
          rm[ea[11:2]] = r[ra];
          exp_addr.push_back(ea);
          exp_data.push_back(r[ra]);
          count++;
        end
        op_bra:  pc = pc + imm;
        op_beq:  if (r[ra] == r[rb]) pc = pc + imm;
        op_bne:  if (r[ra] != r[rb]) pc = pc + imm;
        default: return count;  // halt or undefined
      endcase
    end
    return count;
  endfunction

  // memory model responding 1 ns after each rising edge
  initial begin
    waitrequest = 1'b0;
    readdata    = '0;
    busy        = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (busy && !waitrequest) busy = 1'b0;  // transfer ended at this edge
      if (!busy && reset_n === 1'b1 && (read || write)) begin
        busy      = 1'b1;
        wait_left = $urandom % 4;
      end
      readdata = 32'hdead_beef;
      if (busy && wait_left > 0) begin
        waitrequest = 1'b1;
        wait_left--;
      end else begin
        waitrequest = 1'b0;
        if (busy && read) readdata = mem[address[11:2]];
        if (busy && write) mem[address[11:2]] = writedata;
      end
    end
  end

  // store compare and stall stability at mid-cycle
  always @(negedge clk) begin
    if (reset_n === 1'b1) begin
      if (stall_prev) begin
        assert (address === stall_addr && writedata === stall_wdata &&
                read === stall_rd && write === stall_wr)
        else begin
          protocol_errors++;
          $display("ERROR: t=%0t bus changed in a stall, addr %h -> %h, wdata %h -> %h",
                   $time, stall_addr, address, stall_wdata, writedata);
        end
      end
      stall_prev  = (read || write) && waitrequest;
      stall_addr  = address;
      stall_wdata = writedata;
      stall_rd    = read;
      stall_wr    = write;
      if (write && !waitrequest) begin
        if (stores_seen < exp_addr.size()) begin
          assert (address == exp_addr[stores_seen] && writedata == exp_data[stores_seen])
          else begin
            value_errors++;
            $display("ERROR: t=%0t store %0d got addr %h data %h, expected addr %h data %h",
                     $time, stores_seen, address, writedata,
                     exp_addr[stores_seen], exp_data[stores_seen]);
          end
        end else begin
          protocol_errors++;
          $display("Unexpected store to %h at t=%0t beyond the predicted sequence",
                   address, $time);
        end
        stores_seen++;
      end
    end
  end

  initial begin
    int n;
    void'($urandom(32'h2dd4a9b7));
    build_program();
    mem       = image;
    exp_total = run_reference();

    n = 0;
    while (reset_n !== 1'b1 && n < 20) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (reset_n !== 1'b1) begin
      other_errors++;
      $display("Reset was never released");
    end
    assert (!read && !write && !halt)
    else begin
      protocol_errors++;
      $display("ERROR: t=%0t bus strobes or halt high right after reset", $time);
    end
    @(posedge clk);
    #2;
    assert (read && !write && !halt && address == `CPU_RESET_PC)
    else begin
      protocol_errors++;
      $display("ERROR: t=%0t first fetch wrong, read %b addr %h", $time, read, address);
    end

    n = 0;
    while (!halt && n < `CPU_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!halt) begin
      other_errors++;
      $display("Timed out: halt did not rise within %0d cycles", `CPU_TIMEOUT);
    end else begin
      repeat (20) begin
        @(negedge clk);
        assert (halt && !read && !write)
        else begin
          protocol_errors++;
          $display("ERROR: t=%0t bus activity or halt drop after halt", $time);
        end
      end
    end

    if (stores_seen != exp_total) begin
      other_errors++;
      $display("Store count mismatch: saw %0d stores, expected %0d", stores_seen, exp_total);
    end
    $display("errors: value %0d, protocol %0d, other %0d; stores %0d of %0d",
             value_errors, protocol_errors, other_errors, stores_seen, exp_total);
    if (value_errors + protocol_errors + other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset_n = 1'b1;
  end

endmodule

// File: verilog/cpu_core.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core
  import cpu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 waitrequest,
  input  logic [`CPU_XLEN-1:0] readdata,
  output logic [`CPU_XLEN-1:0] address,
  output logic [`CPU_XLEN-1:0] writedata,
  output logic                 read,
  output logic                 write,
  output logic                 halt
);

  ctrl_word_t ctrl;
  alu_flags_t ccr;
  alu_flags_t alu_flags;

  logic [`CPU_XLEN-1:0]   pc, ir, mar, mdr, aluval;
  logic [`CPU_XLEN-1:0]   alu_out, alu_in1, alu_in2;
  logic [`CPU_XLEN-1:0]   data1, data2, reg_data_in;
  logic [`CPU_XLEN-1:0]   imm_sext;
  logic [2*`CPU_XLEN-1:0] product;

  assign imm_sext  = {{(`CPU_XLEN-16){ir[15]}}, ir[15:0]};
  assign address   = ctrl.addr_sel ? mar : pc;
  assign writedata = mdr;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc  <= `CPU_RESET_PC;
      ir  <= '0;
      ccr <= '0;
    end else begin
      case (ctrl.pc_sel)
        pc_plus4:  pc <= pc + `CPU_XLEN'd4;
        pc_branch: pc <= aluval;  // target from exec
        default:   pc <= pc;
      endcase
      if (ctrl.ir_write) ir <= readdata;
      if (ctrl.ccr_write) ccr <= alu_flags;
    end
  end

  always_ff @(posedge clk) begin
    aluval <= alu_out;
    if (ctrl.mar_sel == mar_alu) mar <= alu_out;
    case (ctrl.mdr_sel)
      mdr_bus:     mdr <= readdata;
      mdr_reg1:    mdr <= data1;
      mdr_prod_lo: mdr <= product[`CPU_XLEN-1:0];
      mdr_prod_hi: mdr <= product[2*`CPU_XLEN-1:`CPU_XLEN];
      default:     mdr <= mdr;
    endcase
  end

  always_comb begin
    case (ctrl.reg_sel)
      reg_mdr: reg_data_in = mdr;
      reg_imm: reg_data_in = imm_sext;
      default: reg_data_in = aluval;
    endcase
    alu_in1 = (ctrl.alu1_sel == alu1_pc) ? pc : data1;
    alu_in2 = (ctrl.alu2_sel == alu2_imm) ? imm_sext : data2;
  end

  control con0 (
    .clk         (clk),
    .reset_n     (reset_n),
    .ir          (ir),
    .ccr         (ccr),
    .waitrequest (waitrequest),
    .ctrl        (ctrl),
    .read        (read),
    .write       (write),
    .halt        (halt)
  );

  alu alu0 (
    .in1    (alu_in1),
    .in2    (alu_in2),
    .op     (ctrl.alu_op),
    .result (alu_out),
    .flags  (alu_flags)
  );

  int_mul mul0 (
    .clk     (clk),
    .start   (ctrl.mul_start),
    .in1     (data1),
    .in2     (data2),
    .product (product)
  );

  register_file regs0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .read_addr1 (ctrl.reg_read_addr1),
    .read_addr2 (ctrl.reg_read_addr2),
    .write_addr (ctrl.reg_write_addr),
    .write_data (reg_data_in),
    .write_en   (ctrl.reg_write),
    .data1      (data1),
    .data2      (data2)
  );

  no_read_write: assert property (@(posedge clk) disable iff (!reset_n)
    !(read && write));

  strobe_aligned: assert property (@(posedge clk) disable iff (!reset_n)
    (read || write) |-> (address[1:0] == 2'b00));

  // a stalled request keeps every bus output steady
  stall_stable: assert property (@(posedge clk) disable iff (!reset_n)
    ((read || write) && waitrequest) |=>
      ($stable(address) && $stable(writedata) && $stable(read) && $stable(write)));

endmodule

// File: verilog/control.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module control
  import cpu_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [`CPU_XLEN-1:0] ir,
  input  alu_flags_t           ccr,
  input  logic                 waitrequest,
  output ctrl_word_t           ctrl,
  output logic                 read,
  output logic                 write,
  output logic                 halt
);

  state_e                  state;
  state_e                  state_next;
  opcode_e                 opcode;
  logic [`CPU_RADDR_W-1:0] ra;
  logic [`CPU_RADDR_W-1:0] rb;
  logic [`CPU_RADDR_W-1:0] rc;
  logic                    take_branch;

  assign opcode = opcode_e'(ir[31:28]);
  assign ra     = ir[27:24];
  assign rb     = ir[23:20];
  assign rc     = ir[19:16];

  always_comb begin
    case (opcode)
      op_bra:  take_branch = 1'b1;
      op_beq:  take_branch = ccr.zero;
      op_bne:  take_branch = !ccr.zero;
      default: take_branch = 1'b0;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      fetch: state_next = fetch_wait;
      fetch_wait: begin
        if (!waitrequest) state_next = decode;
      end
      decode: begin
        case (opcode)
          op_ld, op_st: state_next = mem_addr;
          op_nop, op_ldi, op_add, op_sub, op_and, op_or, op_xor,
          op_mul, op_mulh, op_bra, op_beq, op_bne: state_next = exec;
          default: state_next = halted;  // halt and undefined opcodes
        endcase
      end
      exec: begin
        case (opcode)
          op_mul, op_mulh:        state_next = mul_wait;
          op_bra, op_beq, op_bne: state_next = branch;
          default:                state_next = write_back;
        endcase
      end
      mul_wait: state_next = write_back;
      mem_addr: state_next = (opcode == op_st) ? mem_write : mem_read;
      mem_read: begin
        if (!waitrequest) state_next = write_back;
      end
      mem_write: begin
        if (!waitrequest) state_next = write_back;
      end
      write_back: state_next = fetch_wait;
      branch:     state_next = fetch_wait;
      halted:     state_next = halted;
      default:    state_next = halted;
    endcase
  end

  // strobes follow the next state so they rise with it and stay flat in a stall
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= fetch;
      read  <= 1'b0;
      write <= 1'b0;
    end else begin
      state <= state_next;
      read  <= (state_next == fetch_wait) || (state_next == mem_read);
      write <= (state_next == mem_write);
    end
  end

  assign halt = (state == halted);

  always_comb begin
    ctrl                = '0;
    ctrl.pc_sel         = pc_hold;
    ctrl.mar_sel        = mar_hold;
    ctrl.mdr_sel        = mdr_hold;
    ctrl.reg_sel        = reg_alu;
    ctrl.alu1_sel       = alu1_reg1;
    ctrl.alu2_sel       = alu2_reg2;
    ctrl.alu_op         = alu_pass_b;
    ctrl.reg_read_addr1 = rb;
    ctrl.reg_read_addr2 = rc;
    ctrl.reg_write_addr = ra;
    case (state)
      fetch_wait: begin
        if (!waitrequest) begin
          ctrl.ir_write = 1'b1;
          ctrl.pc_sel   = pc_plus4;
        end
      end
      decode: begin
        case (opcode)
          op_beq, op_bne: begin  // compare ra with rb
            ctrl.reg_read_addr1 = ra;
            ctrl.reg_read_addr2 = rb;
            ctrl.alu_op         = alu_sub;
            ctrl.ccr_write      = 1'b1;
          end
          op_st: begin
            ctrl.reg_read_addr1 = ra;
            ctrl.mdr_sel        = mdr_reg1;  // store data
          end
          default: ;
        endcase
      end
      exec: begin
        case (opcode)
          op_add, op_sub, op_and, op_or, op_xor: begin
            ctrl.ccr_write = 1'b1;
            case (opcode)
              op_add:  ctrl.alu_op = alu_add;
              op_sub:  ctrl.alu_op = alu_sub;
              op_and:  ctrl.alu_op = alu_and;
              op_or:   ctrl.alu_op = alu_or;
              default: ctrl.alu_op = alu_xor;
            endcase
          end
          op_mul, op_mulh: ctrl.mul_start = 1'b1;
          op_bra, op_beq, op_bne: begin
            ctrl.alu1_sel = alu1_pc;  // pc already points past the branch
            ctrl.alu2_sel = alu2_imm;
            ctrl.alu_op   = alu_add;
          end
          default: ;
        endcase
      end
      mul_wait: ctrl.mdr_sel = (opcode == op_mulh) ? mdr_prod_hi : mdr_prod_lo;
      mem_addr: begin
        ctrl.alu2_sel = alu2_imm;
        ctrl.alu_op   = alu_add;
        ctrl.mar_sel  = mar_alu;
      end
      mem_read: begin
        ctrl.addr_sel = 1'b1;
        if (!waitrequest) ctrl.mdr_sel = mdr_bus;
      end
      mem_write: ctrl.addr_sel = 1'b1;
      write_back: begin
        case (opcode)
          op_ldi: begin
            ctrl.reg_sel   = reg_imm;
            ctrl.reg_write = 1'b1;
          end
          op_ld, op_mul, op_mulh: begin
            ctrl.reg_sel   = reg_mdr;
            ctrl.reg_write = 1'b1;
          end
          op_add, op_sub, op_and, op_or, op_xor: ctrl.reg_write = 1'b1;
          default: ;  // nop and st write nothing
        endcase
      end
      branch: begin
        if (take_branch) ctrl.pc_sel = pc_branch;
      end
      default: ;
    endcase
  end

  state_known: assert property (@(posedge clk) disable iff (!reset_n)
    !$isunknown(state));

  bad_opcode_halts: assert property (@(posedge clk) disable iff (!reset_n)
    (state == decode && ir[31:28] == 4'hf) |=> (state == halted));

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register_file (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic [`CPU_RADDR_W-1:0] read_addr1,
  input  logic [`CPU_RADDR_W-1:0] read_addr2,
  input  logic [`CPU_RADDR_W-1:0] write_addr,
  input  logic [`CPU_XLEN-1:0]    write_data,
  input  logic                    write_en,
  output logic [`CPU_XLEN-1:0]    data1,
  output logic [`CPU_XLEN-1:0]    data2
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

  // r0 is a normal register here
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[write_addr] <= write_data;
    end
  end

  // async read ports
  assign data1 = regs[read_addr1];
  assign data2 = regs[read_addr2];

endmodule

// File: verilog/int_mul.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module int_mul #(
  parameter bit SIGNED = `CPU_MUL_SIGNED
) (
  input  logic                     clk,
  input  logic                     start,
  input  logic [`CPU_XLEN-1:0]     in1,
  input  logic [`CPU_XLEN-1:0]     in2,
  output logic [2*`CPU_XLEN-1:0]   product
);

  logic [2*`CPU_XLEN-1:0] product_next;

  generate
    if (SIGNED) begin : g_signed
      // operands sign-extend to the full 64-bit context
      assign product_next = $signed(in1) * $signed(in2);
    end else begin : g_unsigned
      assign product_next = in1 * in2;
    end
  endgenerate

  // product holds until the next start
  always_ff @(posedge clk) begin
    if (start) begin
      product <= product_next;
    end
  end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu
  import cpu_pkg::*;
(
  input  logic [`CPU_XLEN-1:0] in1,
  input  logic [`CPU_XLEN-1:0] in2,
  input  alu_op_e              op,
  output logic [`CPU_XLEN-1:0] result,
  output alu_flags_t           flags
);

  localparam int MSB = `CPU_XLEN - 1;

  logic [`CPU_XLEN:0] sum;
  logic [`CPU_XLEN:0] diff;

  assign sum  = {1'b0, in1} + {1'b0, in2};
  assign diff = {1'b0, in1} - {1'b0, in2};

  always_comb begin
    flags.carry    = 1'b0;
    flags.overflow = 1'b0;
    case (op)
      alu_add: begin
        result         = sum[MSB:0];
        flags.carry    = sum[`CPU_XLEN];
        flags.overflow = (in1[MSB] == in2[MSB]) && (sum[MSB] != in1[MSB]);
      end
      alu_sub: begin
        result         = diff[MSB:0];
        flags.carry    = diff[`CPU_XLEN];  // borrow out
        flags.overflow = (in1[MSB] != in2[MSB]) && (diff[MSB] != in1[MSB]);
      end
      alu_and:    result = in1 & in2;
      alu_or:     result = in1 | in2;
      alu_xor:    result = in1 ^ in2;
      alu_pass_b: result = in2;
      default:    result = in2;
    endcase
    flags.negative = result[MSB];
    flags.zero     = (result == '0);
  end

endmodule

// File: verilog/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

  typedef enum logic [3:0] {
    op_nop  = 4'h0,
    op_ldi  = 4'h1,
    op_add  = 4'h2,
    op_sub  = 4'h3,
    op_and  = 4'h4,
    op_or   = 4'h5,
    op_xor  = 4'h6,
    op_mul  = 4'h7,
    op_mulh = 4'h8,
    op_ld   = 4'h9,
    op_st   = 4'ha,
    op_bra  = 4'hb,
    op_beq  = 4'hc,
    op_bne  = 4'hd,
    op_halt = 4'he  // 4'hf is undefined
  } opcode_e;

  typedef enum logic [3:0] {
    fetch,
    fetch_wait,
    decode,
    exec,
    mul_wait,
    mem_addr,
    mem_read,
    mem_write,
    write_back,
    branch,
    halted
  } state_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {pc_hold, pc_plus4, pc_branch} pc_sel_e;
  typedef enum logic [0:0] {mar_hold, mar_alu} mar_sel_e;
  typedef enum logic [2:0] {mdr_hold, mdr_bus, mdr_reg1, mdr_prod_lo, mdr_prod_hi} mdr_sel_e;
  typedef enum logic [1:0] {reg_alu, reg_mdr, reg_imm} reg_sel_e;
  typedef enum logic [0:0] {alu1_reg1, alu1_pc} alu1_sel_e;
  typedef enum logic [0:0] {alu2_reg2, alu2_imm} alu2_sel_e;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } alu_flags_t;

  typedef struct packed {
    pc_sel_e                 pc_sel;
    mar_sel_e                mar_sel;
    mdr_sel_e                mdr_sel;
    reg_sel_e                reg_sel;
    alu1_sel_e               alu1_sel;
    alu2_sel_e               alu2_sel;
    alu_op_e                 alu_op;
    logic                    reg_write;
    logic [`CPU_RADDR_W-1:0] reg_read_addr1;
    logic [`CPU_RADDR_W-1:0] reg_read_addr2;
    logic [`CPU_RADDR_W-1:0] reg_write_addr;
    logic                    ir_write;
    logic                    ccr_write;
    logic                    mul_start;
    logic                    addr_sel;  // 1 puts mar on the bus
  } ctrl_word_t;

endpackage

// File: verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and address width
`define CPU_XLEN 32

// general register file
`define CPU_NREGS   16
`define CPU_RADDR_W 4

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

// cycles the bench waits for halt
`define CPU_TIMEOUT 20000

// 1 gives a signed product, 0 unsigned
`define CPU_MUL_SIGNED 1'b1

`endif
